// ==== include/bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

`define BP_PC_WIDTH 32

`define BP_BTB_ENTRIES 64
`define BP_BTB_INDEX_WIDTH 6

// history width doubles as the pattern table index width.
`define BP_PHT_ENTRIES 256
`define BP_HISTORY_WIDTH 8

`define BP_RAS_ENTRIES 8
`define BP_RAS_PTR_WIDTH 3

`endif

// ==== src/bp_addr_pkg.sv ====
`include "bp_defs.svh"

package bp_addr_pkg;

  // program counter or target address.
  typedef logic [`BP_PC_WIDTH-1:0] pc_t;

  // pc bits 6 to 1, bit 0 is unused with compressed instructions.
  typedef logic [`BP_BTB_INDEX_WIDTH-1:0] btb_index_t;

  // pc bits 31 to 7.
  typedef logic [`BP_PC_WIDTH-`BP_BTB_INDEX_WIDTH-2:0] btb_tag_t;

  // history xor pc bits 8 to 1.
  typedef logic [`BP_HISTORY_WIDTH-1:0] pht_index_t;

endpackage

// ==== src/bp_state_pkg.sv ====
`include "bp_defs.svh"

package bp_state_pkg;

  // two-bit saturating counter, upper bit is the prediction.
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } sat_t;

  // newest outcome in bit 0.
  typedef logic [`BP_HISTORY_WIDTH-1:0] history_t;

  typedef logic [`BP_RAS_PTR_WIDTH-1:0] ras_ptr_t;

  // one bit wider than the pointer so a full stack counts to 8.
  typedef logic [`BP_RAS_PTR_WIDTH:0] ras_count_t;

endpackage

// ==== src/branch_target_buffer.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_target_buffer
  import bp_addr_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  pc_t  lookup_pc,
  output logic hit,
  output pc_t  target,
  input  logic write,
  input  pc_t  write_pc,
  input  pc_t  write_target
);

  btb_tag_t   tags    [`BP_BTB_ENTRIES];
  pc_t        targets [`BP_BTB_ENTRIES];
  logic [`BP_BTB_ENTRIES-1:0] valid;

  btb_index_t lookup_index;
  btb_tag_t   lookup_tag;
  btb_index_t write_index;
  btb_tag_t   write_tag;

  assign lookup_index = lookup_pc[`BP_BTB_INDEX_WIDTH:1];
  assign lookup_tag   = lookup_pc[`BP_PC_WIDTH-1:`BP_BTB_INDEX_WIDTH+1];
  assign write_index  = write_pc[`BP_BTB_INDEX_WIDTH:1];
  assign write_tag    = write_pc[`BP_PC_WIDTH-1:`BP_BTB_INDEX_WIDTH+1];

  // old contents are seen until the edge.
  assign hit    = valid[lookup_index] && (tags[lookup_index] == lookup_tag);
  assign target = targets[lookup_index];

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid <= '0;
    end else if (write) begin
      valid[write_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write) begin
      tags[write_index]    <= write_tag;
      targets[write_index] <= write_target;
    end
  end

  // write term comes from the resolve stage through the top level.
  write_known: assert property (
    @(posedge clock) disable iff (!reset) !$isunknown(write)
  );

endmodule

// ==== src/gshare_predictor.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module gshare_predictor
  import bp_addr_pkg::*;
  import bp_state_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  pc_t  lookup_pc,
  output logic taken,
  input  logic train,
  input  pc_t  train_pc,
  input  logic outcome
);

  history_t   history;
  sat_t       counters [`BP_PHT_ENTRIES];

  pht_index_t lookup_index;
  pht_index_t train_index;
  sat_t       lookup_count;
  sat_t       train_count;
  sat_t       train_next;

  assign lookup_index = history ^ lookup_pc[`BP_HISTORY_WIDTH:1];
  assign train_index  = history ^ train_pc[`BP_HISTORY_WIDTH:1];

  // two read ports.
  assign lookup_count = counters[lookup_index];
  assign train_count  = counters[train_index];

  assign taken = lookup_count[1];

  // one step toward the outcome, held at both ends.
  always_comb begin
    train_next = train_count;
    if (outcome) begin
      if (train_count != strong_taken) begin
        train_next = sat_t'(train_count + 2'd1);
      end
    end else begin
      if (train_count != strong_not_taken) begin
        train_next = sat_t'(train_count - 2'd1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      history <= '0;
      for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
        counters[i] <= strong_not_taken;
      end
    end else if (train) begin
      counters[train_index] <= train_next;
      history <= {history[`BP_HISTORY_WIDTH-2:0], outcome};
    end
  end

  history_only_on_train: assert property (
    @(posedge clock) disable iff (!reset) !$stable(history) |-> $past(train)
  );

endmodule

// ==== src/return_address_stack.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module return_address_stack
  import bp_addr_pkg::*;
  import bp_state_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic push,
  input  pc_t  push_addr,
  input  logic pop,
  output logic valid,
  output pc_t  top_addr
);

  localparam ras_count_t ras_full = ras_count_t'(`BP_RAS_ENTRIES);

  pc_t        stack [`BP_RAS_ENTRIES];
  ras_ptr_t   ptr;
  ras_count_t count;

  logic       pop_take;
  ras_ptr_t   write_ptr;

  assign valid    = (count != '0);
  assign top_addr = stack[ptr];

  // pop on an empty stack is ignored.
  assign pop_take = pop && valid;

  // push with pop replaces the top in place.
  assign write_ptr = pop_take ? ptr : ras_ptr_t'(ptr + 1'b1);

  always_ff @(posedge clock) begin
    if (!reset) begin
      ptr   <= '0;
      count <= '0;
    end else if (push && pop_take) begin
      ptr   <= ptr;
      count <= count;
    end else if (push) begin
      // full stack wraps onto the oldest entry.
      ptr <= write_ptr;
      if (count != ras_full) begin
        count <= count + 1'b1;
      end
    end else if (pop_take) begin
      ptr   <= ptr - 1'b1;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      stack[write_ptr] <= push_addr;
    end
  end

  count_bounded: assert property (
    @(posedge clock) disable iff (!reset) count <= ras_full
  );

endmodule

// ==== src/branch_predictor.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_predictor
  import bp_addr_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  pc_t  get_pc,
  input  logic get_branch,
  input  logic get_uncond,
  input  logic get_return,
  input  pc_t  upd_pc,
  input  pc_t  upd_target,
  input  pc_t  upd_npc,
  input  logic upd_branch,
  input  logic upd_taken,
  input  logic upd_uncond,
  input  logic upd_return,
  input  logic stall,
  input  logic clear,
  output pc_t  pred_taddr,
  output logic pred_branch,
  output logic pred_uncond,
  output logic pred_jump,
  output pc_t  pred_raddr,
  output logic pred_return
);

  logic qualified;
  logic btb_write;
  logic btb_hit;
  pc_t  btb_target;
  logic gshare_taken;
  logic pop;
  logic ras_valid;
  pc_t  ras_top;

  // a taken resolve redirects fetch, so the current lookup is dropped.
  assign qualified = !stall && !clear && !upd_taken;
  assign btb_write = upd_uncond || (upd_branch && upd_taken);
  assign pop       = get_return && qualified;

  branch_target_buffer u_btb (
    .clock        (clock),
    .reset        (reset),
    .lookup_pc    (get_pc),
    .hit          (btb_hit),
    .target       (btb_target),
    .write        (btb_write),
    .write_pc     (upd_pc),
    .write_target (upd_target)
  );

  gshare_predictor u_gshare (
    .clock     (clock),
    .reset     (reset),
    .lookup_pc (get_pc),
    .taken     (gshare_taken),
    .train     (upd_branch),
    .train_pc  (upd_pc),
    .outcome   (upd_taken)
  );

  return_address_stack u_ras (
    .clock     (clock),
    .reset     (reset),
    .push      (upd_return),
    .push_addr (upd_npc),
    .pop       (pop),
    .valid     (ras_valid),
    .top_addr  (ras_top)
  );

  assign pred_taddr  = (btb_hit && qualified) ? btb_target : {`BP_PC_WIDTH{1'b0}};
  assign pred_branch = btb_hit && qualified && get_branch;
  assign pred_uncond = btb_hit && qualified && get_uncond;

  // direction needs no btb hit.
  assign pred_jump   = qualified && get_branch && gshare_taken;

  assign pred_return = pop && ras_valid;
  assign pred_raddr  = pred_return ? ras_top : {`BP_PC_WIDTH{1'b0}};

endmodule

// ==== sim/branch_predictor_tb.sv ====
`timescale 1ns/1ps

module branch_predictor_tb
  import bp_addr_pkg::*;
();

  typedef struct packed {
    logic [7:0] test;
    pc_t  get_pc;
    logic get_branch, get_uncond, get_return;
    pc_t  upd_pc, upd_target, upd_npc;
    logic upd_branch, upd_taken, upd_uncond, upd_return, stall, clear;
    pc_t  exp_taddr;
    logic exp_branch, exp_uncond, exp_jump;
    pc_t  exp_raddr;
    logic exp_return;
  } row_t;

  localparam pc_t pc_a = 32'h0000_2040;
  // same btb index as pc_a with the tag one higher.
  localparam pc_t pc_b = 32'h0000_20c0;
  localparam pc_t target_a = 32'h0000_8000;
  localparam pc_t target_b = 32'h0000_4000;
  localparam pc_t ret_q = 32'h0000_7000;

  logic clock, reset, stall, clear;
  pc_t  get_pc, upd_pc, upd_target, upd_npc;
  logic get_branch, get_uncond, get_return;
  logic upd_branch, upd_taken, upd_uncond, upd_return;
  pc_t  pred_taddr, pred_raddr;
  logic pred_branch, pred_uncond, pred_jump, pred_return;

  row_t rows[$];
  row_t r;
  int   cycles = 0;
  int   cycle_limit = 1000;
  int   errors = 0;
  int   test_errors = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;

  branch_predictor u_branch_predictor (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run hung: stimulus table not finished after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // pc bit 0 never reaches an index or a tag.
  function automatic pc_t with_random_lsb(input pc_t pc);
    return {pc[31:1], 1'($urandom)};
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1: return "after reset";
      2: return "btb";
      3: return "gshare";
      4: return "return stack";
      default: return "qualification";
    endcase
  endfunction

  task automatic begin_row(input int test);
    r = '0;
    r.test = 8'(test);
    r.get_pc = with_random_lsb('0);
    r.upd_pc = with_random_lsb('0);
  endtask

  task automatic set_lookup(input pc_t pc, input logic br, input logic un, input logic ret);
    r.get_pc = with_random_lsb(pc);
    r.get_branch = br;
    r.get_uncond = un;
    r.get_return = ret;
  endtask

  task automatic set_update(input pc_t pc, input pc_t target, input pc_t npc,
                            input logic br, input logic tk, input logic un, input logic ret);
    r.upd_pc = with_random_lsb(pc);
    r.upd_target = target;
    r.upd_npc = npc;
    r.upd_branch = br;
    r.upd_taken = tk;
    r.upd_uncond = un;
    r.upd_return = ret;
  endtask

  task automatic expect_btb(input pc_t taddr, input logic br, input logic un);
    r.exp_taddr = taddr;
    r.exp_branch = br;
    r.exp_uncond = un;
  endtask

  task automatic train_row(input int test, input pc_t pc, input logic tk);
    begin_row(test);
    set_update(pc, target_b, '0, 1'b1, tk, 1'b0, 1'b0);
    rows.push_back(r);
  endtask

  // branch lookup at a pc with no btb entry.
  task automatic branch_probe_row(input int test, input pc_t pc, input logic jump);
    begin_row(test);
    set_lookup(pc, 1'b1, 1'b0, 1'b0);
    r.exp_jump = jump;
    rows.push_back(r);
  endtask

  task automatic push_row(input int test, input pc_t addr);
    begin_row(test);
    set_update('0, '0, addr, 1'b0, 1'b0, 1'b0, 1'b1);
    rows.push_back(r);
  endtask

  task automatic pop_row(input int test, input pc_t addr, input logic valid);
    begin_row(test);
    set_lookup('0, 1'b0, 1'b0, 1'b1);
    r.exp_return = valid;
    r.exp_raddr = valid ? addr : '0;
    rows.push_back(r);
  endtask

  task automatic build_table();
    begin_row(1);
    set_lookup(32'h0000_1000, 1'b1, 1'b1, 1'b1);
    rows.push_back(r);
    begin_row(1);
    set_lookup(pc_a, 1'b1, 1'b1, 1'b1);
    rows.push_back(r);
    // written this cycle, so the lookup still misses.
    begin_row(2);
    set_lookup(pc_a, 1'b0, 1'b1, 1'b0);
    set_update(pc_a, target_a, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    rows.push_back(r);
    begin_row(2);
    set_lookup(pc_a, 1'b0, 1'b1, 1'b0);
    expect_btb(target_a, 1'b0, 1'b1);
    rows.push_back(r);
    begin_row(2);
    set_lookup(pc_b, 1'b0, 1'b1, 1'b0);
    rows.push_back(r);
    begin_row(2);
    set_lookup(pc_a, 1'b1, 1'b0, 1'b0);
    expect_btb(target_a, 1'b1, 1'b0);
    rows.push_back(r);
    // up to the 0x31ac probe every pc lands on counter 0x08 under the history then.
    train_row(3, 32'h0000_3010, 1'b1);
    branch_probe_row(3, 32'h0000_3012, 1'b0);
    train_row(3, 32'h0000_3012, 1'b1);
    branch_probe_row(3, 32'h0000_3016, 1'b1);
    train_row(3, 32'h0000_3016, 1'b0);
    branch_probe_row(3, 32'h0000_301c, 1'b0);
    train_row(3, 32'h0000_301c, 1'b1);
    train_row(3, 32'h0000_300a, 1'b1);
    train_row(3, 32'h0000_3026, 1'b1);
    train_row(3, 32'h0000_307e, 1'b1);
    train_row(3, 32'h0000_30ce, 1'b0);
    branch_probe_row(3, 32'h0000_31ac, 1'b1);
    // same counter without the branch flag.
    begin_row(3);
    set_lookup(32'h0000_31ac, 1'b0, 1'b0, 1'b0);
    rows.push_back(r);
    // only taken branches fill the btb.
    begin_row(3);
    set_lookup(32'h0000_3026, 1'b1, 1'b0, 1'b0);
    expect_btb(target_b, 1'b1, 1'b0);
    rows.push_back(r);
    branch_probe_row(3, 32'h0000_3016, 1'b0);
    for (int i = 1; i <= 3; i++) push_row(4, pc_t'(32'h0000_5000 + 4 * i));
    for (int i = 3; i >= 1; i--) pop_row(4, pc_t'(32'h0000_5000 + 4 * i), 1'b1);
    pop_row(4, '0, 1'b0);
    // nine pushes overwrite the oldest.
    for (int i = 1; i <= 9; i++) push_row(4, pc_t'(32'h0000_6000 + 4 * i));
    for (int i = 9; i >= 2; i--) pop_row(4, pc_t'(32'h0000_6000 + 4 * i), 1'b1);
    pop_row(4, '0, 1'b0);
    push_row(5, ret_q);
    begin_row(5);
    set_lookup(pc_a, 1'b1, 1'b1, 1'b1);
    r.stall = 1'b1;
    rows.push_back(r);
    begin_row(5);
    set_lookup(pc_a, 1'b1, 1'b1, 1'b1);
    r.clear = 1'b1;
    rows.push_back(r);
    begin_row(5);
    set_lookup(pc_a, 1'b1, 1'b1, 1'b1);
    r.upd_taken = 1'b1;
    rows.push_back(r);
    // counter 0x08 still predicts taken here.
    begin_row(5);
    set_lookup(32'h0000_31ac, 1'b1, 1'b0, 1'b0);
    r.stall = 1'b1;
    rows.push_back(r);
    begin_row(5);
    set_lookup(pc_a, 1'b0, 1'b1, 1'b1);
    expect_btb(target_a, 1'b0, 1'b1);
    r.exp_return = 1'b1;
    r.exp_raddr = ret_q;
    rows.push_back(r);
  endtask

  task automatic apply_row(input row_t d);
    get_pc = d.get_pc;
    get_branch = d.get_branch;
    get_uncond = d.get_uncond;
    get_return = d.get_return;
    upd_pc = d.upd_pc;
    upd_target = d.upd_target;
    upd_npc = d.upd_npc;
    upd_branch = d.upd_branch;
    upd_taken = d.upd_taken;
    upd_uncond = d.upd_uncond;
    upd_return = d.upd_return;
    stall = d.stall;
    clear = d.clear;
  endtask

  task automatic value_error(input string name, input pc_t expected, input pc_t actual);
    $display("ERROR at %0t: %s expected 0x%h, actual 0x%h", $time, name, expected, actual);
    errors++;
    test_errors++;
  endtask

  task automatic check_row(input row_t e);
    if (pred_taddr !== e.exp_taddr) begin
      value_error("pred_taddr", e.exp_taddr, pred_taddr);
    end
    if (pred_branch !== e.exp_branch) begin
      value_error("pred_branch", 32'(e.exp_branch), 32'(pred_branch));
    end
    if (pred_uncond !== e.exp_uncond) begin
      value_error("pred_uncond", 32'(e.exp_uncond), 32'(pred_uncond));
    end
    if (pred_jump !== e.exp_jump) begin
      value_error("pred_jump", 32'(e.exp_jump), 32'(pred_jump));
    end
    if (pred_raddr !== e.exp_raddr) begin
      value_error("pred_raddr", e.exp_raddr, pred_raddr);
    end
    if (pred_return !== e.exp_return) begin
      value_error("pred_return", 32'(e.exp_return), 32'(pred_return));
    end
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'haad));
    begin_row(0);
    apply_row(r);
    reset = 1'b0;
    build_table();
    cycle_limit = rows.size() + 20;
    repeat (2) @(posedge clock);
    #2 reset = 1'b1;
    for (int n = 0; n < rows.size(); n++) begin
      @(posedge clock);
      #2 apply_row(rows[n]);
      #36 check_row(rows[n]);
      if (n == rows.size() - 1 || rows[n + 1].test != rows[n].test) begin
        $display("test %0d (%s) done, %0d errors", rows[n].test, test_name(int'(rows[n].test)),
                 test_errors);
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        test_errors = 0;
      end
    end
    $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed, tests_failed,
             errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
src/bp_addr_pkg.sv
src/bp_state_pkg.sv
src/branch_target_buffer.sv
src/gshare_predictor.sv
src/return_address_stack.sv
src/branch_predictor.sv
sim/branch_predictor_tb.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' sources.f) include/bp_defs.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vbranch_predictor_tb: sources.f $(SOURCES)
	verilator --binary --timing --assert -f sources.f --top-module branch_predictor_tb -j 0

run: obj_dir/Vbranch_predictor_tb
	./obj_dir/Vbranch_predictor_tb | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
